/* include/rsa_settings.svh */
// operand width and counter width macros for the rsa exponentiation core
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

// operand width in bits
`define RSA_WIDTH 256

// bit and round index width, covers 0..255
`define RSA_CNT_W 8

`endif

/* logic/rsa_types_pkg.sv */
// package rsa_types_pkg: operand and accumulator data types
`default_nettype none

`include "rsa_settings.svh"

package rsa_types_pkg;

    // modulus, exponent, base, result
    typedef logic [`RSA_WIDTH-1:0] rsa_operand_t;

    // montgomery sum before the shift, two guard bits
    typedef logic [`RSA_WIDTH+1:0] rsa_acc_t;

endpackage

`default_nettype wire

/* logic/rsa_ctrl_pkg.sv */
// package rsa_ctrl_pkg: sequencer state enum and bit/round index type
`default_nettype none

`include "rsa_settings.svh"

package rsa_ctrl_pkg;

    typedef logic [`RSA_CNT_W-1:0] rsa_idx_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREP,
        S_MUL,
        S_FIX,
        S_LOAD,
        S_DONE
    } rsa_seq_state_e;

endpackage

`default_nettype wire

/* logic/rsa_bit_counter.sv */
// module rsa_bit_counter: clearable enabled index counter with last flag
`timescale 1ns/1ps
`default_nettype none

module rsa_bit_counter (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_clear,
    input  logic                   i_en,
    output rsa_ctrl_pkg::rsa_idx_t o_idx,
    output logic                   o_last
);

    import rsa_ctrl_pkg::*;

    rsa_idx_t idx;

    // wraps naturally from 255 back to 0
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            idx <= '0;
        end else if (i_clear) begin
            idx <= '0;
        end else if (i_en) begin
            idx <= idx + 1'b1;
        end
    end

    assign o_idx  = idx;
    assign o_last = (idx == '1);

endmodule

`default_nettype wire

/* logic/rsa_sequencer.sv */
// module rsa_sequencer: FSM for preparation, multiply rounds, fix, load and ready
`timescale 1ns/1ps
`default_nettype none

module rsa_sequencer (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_valid,
    input  logic i_bit_last,
    input  logic i_rnd_last,
    output logic o_capture,
    output logic o_prep_step,
    output logic o_mul_clear,
    output logic o_mul_step,
    output logic o_mul_fix,
    output logic o_load,
    output logic o_bit_clear,
    output logic o_bit_en,
    output logic o_rnd_clear,
    output logic o_rnd_en,
    output logic o_ready
);

    import rsa_ctrl_pkg::*;

    rsa_seq_state_e state;
    rsa_seq_state_e state_nxt;
    logic           ready;

    ////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////

    always_comb begin
        state_nxt   = state;
        o_capture   = 1'b0;
        o_prep_step = 1'b0;
        o_mul_clear = 1'b0;
        o_mul_step  = 1'b0;
        o_mul_fix   = 1'b0;
        o_load      = 1'b0;
        o_bit_clear = 1'b0;
        o_bit_en    = 1'b0;
        o_rnd_clear = 1'b0;
        o_rnd_en    = 1'b0;
        case (state)
            S_IDLE: begin
                if (i_valid) begin
                    o_capture   = 1'b1;
                    o_bit_clear = 1'b1;
                    o_rnd_clear = 1'b1;
                    state_nxt   = S_PREP;
                end
            end
            S_PREP: begin
                o_prep_step = 1'b1;
                o_bit_en    = 1'b1;
                // multipliers start from zero on the first round
                if (i_bit_last) begin
                    o_mul_clear = 1'b1;
                    state_nxt   = S_MUL;
                end
            end
            S_MUL: begin
                o_mul_step = 1'b1;
                o_bit_en   = 1'b1;
                if (i_bit_last) begin
                    state_nxt = S_FIX;
                end
            end
            S_FIX: begin
                o_mul_fix = 1'b1;
                state_nxt = S_LOAD;
            end
            S_LOAD: begin
                o_load   = 1'b1;
                o_rnd_en = 1'b1;
                if (i_rnd_last) begin
                    state_nxt = S_DONE;
                end else begin
                    o_mul_clear = 1'b1;
                    state_nxt   = S_MUL;
                end
            end
            S_DONE: begin
                state_nxt = S_IDLE;
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // state and ready registers
    ////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= S_IDLE;
            ready <= 1'b0;
        end else begin
            state <= state_nxt;
            // high exactly while in S_DONE
            ready <= (state_nxt == S_DONE);
        end
    end

    assign o_ready = ready;

endmodule

`default_nettype wire

/* logic/rsa_operand_store.sv */
// operand store with modulus, exponent, base and result registers
`timescale 1ns/1ps
`default_nettype none

module rsa_operand_store (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_capture,
    input  logic                        i_prep_step,
    input  logic                        i_load,
    input  rsa_types_pkg::rsa_operand_t i_n,
    input  rsa_types_pkg::rsa_operand_t i_e,
    input  rsa_types_pkg::rsa_operand_t i_y,
    input  rsa_types_pkg::rsa_operand_t i_sq_p,
    input  rsa_types_pkg::rsa_operand_t i_mul_p,
    output rsa_types_pkg::rsa_operand_t o_n,
    output rsa_types_pkg::rsa_operand_t o_base,
    output rsa_types_pkg::rsa_operand_t o_result
);

    import rsa_types_pkg::*;

    rsa_operand_t n_q;
    rsa_operand_t e_q;
    rsa_operand_t base_q;
    rsa_operand_t result_q;
    rsa_acc_t     dbl;
    rsa_acc_t     dbl_red;

    // modular doubling keeps the base below N
    always_comb begin
        dbl     = rsa_acc_t'({base_q, 1'b0});
        dbl_red = (dbl >= rsa_acc_t'(n_q)) ? dbl - rsa_acc_t'(n_q) : dbl;
    end

    ////////////////////////////////////////
    // operand registers
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            n_q    <= i_n;
            e_q    <= i_e;
            base_q <= i_y;
        end else if (i_prep_step) begin
            base_q <= dbl_red[$bits(rsa_operand_t)-1:0];
        end else if (i_load) begin
            // base squared every round and exponent consumed lsb first
            base_q <= i_sq_p;
            e_q    <= e_q >> 1;
        end
    end

    // result register drives o_text
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            result_q <= '0;
        end else if (i_capture) begin
            result_q <= rsa_operand_t'(1);
        end else if (i_load && e_q[0]) begin
            result_q <= i_mul_p;
        end
    end

    assign o_n      = n_q;
    assign o_base   = base_q;
    assign o_result = result_q;

endmodule

`default_nettype wire

/* logic/mont_mul.sv */
// module mont_mul: bit-serial montgomery product with final conditional subtract
`timescale 1ns/1ps
`default_nettype none

module mont_mul (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_clear,
    input  logic                        i_step,
    input  logic                        i_fix,
    input  rsa_ctrl_pkg::rsa_idx_t      i_idx,
    input  rsa_types_pkg::rsa_operand_t i_a,
    input  rsa_types_pkg::rsa_operand_t i_b,
    input  rsa_types_pkg::rsa_operand_t i_n,
    output rsa_types_pkg::rsa_operand_t o_p
);

    import rsa_types_pkg::*;

    rsa_acc_t acc;
    rsa_acc_t n_ext;
    rsa_acc_t sum_b;
    rsa_acc_t sum_n;
    rsa_acc_t step_nxt;
    rsa_acc_t fix_nxt;

    always_comb begin
        n_ext = rsa_acc_t'(i_n);
        // add b when the selected bit of a is set
        sum_b = i_a[i_idx] ? acc + rsa_acc_t'(i_b) : acc;
        // make the sum even before halving
        sum_n    = sum_b[0] ? sum_b + n_ext : sum_b;
        step_nxt = sum_n >> 1;
        // acc is below 2N here, one subtract is enough
        fix_nxt = (acc >= n_ext) ? acc - n_ext : acc;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            acc <= '0;
        end else if (i_clear) begin
            acc <= '0;
        end else if (i_step) begin
            acc <= step_nxt;
        end else if (i_fix) begin
            acc <= fix_nxt;
        end
    end

    assign o_p = acc[$bits(rsa_operand_t)-1:0];

endmodule

`default_nettype wire

/* logic/rsa_core.sv */
// top level module of the modular exponentiation core
`timescale 1ns/1ps
`default_nettype none

module rsa_core (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_valid,
    input  rsa_types_pkg::rsa_operand_t i_n,
    input  rsa_types_pkg::rsa_operand_t i_e,
    input  rsa_types_pkg::rsa_operand_t i_y,
    output rsa_types_pkg::rsa_operand_t o_text,
    output logic                        o_ready
);

    import rsa_types_pkg::*;
    import rsa_ctrl_pkg::*;

    logic         capture;
    logic         prep_step;
    logic         load;
    logic         mul_clear;
    logic         mul_step;
    logic         mul_fix;
    logic         bit_clear;
    logic         bit_en;
    logic         bit_last;
    logic         rnd_clear;
    logic         rnd_en;
    logic         rnd_last;
    rsa_idx_t     bit_idx;
    rsa_operand_t n_reg;
    rsa_operand_t base;
    rsa_operand_t sq_p;
    rsa_operand_t mul_p;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    rsa_sequencer seq0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_bit_last  (bit_last),
        .i_rnd_last  (rnd_last),
        .o_capture   (capture),
        .o_prep_step (prep_step),
        .o_mul_clear (mul_clear),
        .o_mul_step  (mul_step),
        .o_mul_fix   (mul_fix),
        .o_load      (load),
        .o_bit_clear (bit_clear),
        .o_bit_en    (bit_en),
        .o_rnd_clear (rnd_clear),
        .o_rnd_en    (rnd_en),
        .o_ready     (o_ready)
    );

    // paces prep and mul and supplies the multiplier bit position
    rsa_bit_counter bitcnt0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (bit_clear),
        .i_en    (bit_en),
        .o_idx   (bit_idx),
        .o_last  (bit_last)
    );

    // one tick per exponent bit
    rsa_bit_counter rndcnt0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (rnd_clear),
        .i_en    (rnd_en),
        .o_idx   (),
        .o_last  (rnd_last)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    rsa_operand_store store0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_capture   (capture),
        .i_prep_step (prep_step),
        .i_load      (load),
        .i_n         (i_n),
        .i_e         (i_e),
        .i_y         (i_y),
        .i_sq_p      (sq_p),
        .i_mul_p     (mul_p),
        .o_n         (n_reg),
        .o_base      (base),
        .o_result    (o_text)
    );

    // base times base
    mont_mul sq0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (mul_clear),
        .i_step  (mul_step),
        .i_fix   (mul_fix),
        .i_idx   (bit_idx),
        .i_a     (base),
        .i_b     (base),
        .i_n     (n_reg),
        .o_p     (sq_p)
    );

    // result times base keeps the result outside the montgomery domain
    mont_mul mul0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (mul_clear),
        .i_step  (mul_step),
        .i_fix   (mul_fix),
        .i_idx   (bit_idx),
        .i_a     (o_text),
        .i_b     (base),
        .i_n     (n_reg),
        .o_p     (mul_p)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
// module tb_clock: free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* verif/rsa_core_assertions.sv */
// concurrent ready and strobe properties bound into rsa_core
`timescale 1ns/1ps
`default_nettype none

module rsa_core_assertions (
    input logic i_clk,
    input logic i_rst,
    input logic i_ready,
    input logic i_prep_step,
    input logic i_mul_step,
    input logic i_mul_fix,
    input logic i_load
);

    // number of failed assertions
    int fail_count = 0;

    ready_one_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst) i_ready |=> !i_ready
    ) else begin
        fail_count = fail_count + 1;
        $error("o_ready stayed high for two cycles in a row");
    end

    // prep, mul, fix and load never overlap
    steps_exclusive: assert property (
        @(posedge i_clk) disable iff (i_rst)
            $onehot0({i_prep_step, i_mul_step, i_mul_fix, i_load})
    ) else begin
        fail_count = fail_count + 1;
        $error("more than one sequencer step strobe high");
    end

    ready_low_in_reset: assert property (
        @(posedge i_clk) i_rst |-> !i_ready
    ) else begin
        fail_count = fail_count + 1;
        $error("o_ready high while reset is asserted");
    end

endmodule

bind rsa_core rsa_core_assertions asrt0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_ready     (o_ready),
    .i_prep_step (prep_step),
    .i_mul_step  (mul_step),
    .i_mul_fix   (mul_fix),
    .i_load      (load)
);

`default_nettype wire

/* verif/rsa_core_tb.sv */
// module rsa_core_tb: testbench top for the rsa exponentiation core
`timescale 1ns/1ps
`default_nettype none

`include "rsa_settings.svh"

module rsa_core_tb;

    import rsa_types_pkg::*;

    localparam int          CLK_PERIOD_NS   = 4;
    localparam int          RESET_CYCLES    = 5;
    localparam int          CYCLES_PER_TEST = 70000;
    localparam int          HOLD_CYCLES     = 300;
    localparam int          HEX_DIGITS      = `RSA_WIDTH / 4;
    localparam logic [31:0] SEED            = 32'h04c4_1eb8;
    localparam string       STIM_FILE       = "verif/rsa_stimulus.txt";

    logic         clk;
    logic         rst;
    logic         valid;
    rsa_operand_t op_n;
    rsa_operand_t op_e;
    rsa_operand_t op_y;
    rsa_operand_t text;
    logic         ready;

    logic [7:0]   tv_id[$];
    rsa_operand_t tv_n[$];
    rsa_operand_t tv_e[$];
    rsa_operand_t tv_y[$];
    rsa_operand_t tv_exp[$];
    logic [3:0]   tv_kind[$];

    int errors       = 0;
    int passed       = 0;
    int failed       = 0;
    int ready_pulses = 0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clkgen0 (.o_clk(clk));

    rsa_core dut0 (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_valid (valid),
        .i_n     (op_n),
        .i_e     (op_e),
        .i_y     (op_y),
        .o_text  (text),
        .o_ready (ready)
    );

    always @(posedge clk) begin
        if (ready) begin
            ready_pulses <= ready_pulses + 1;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            4'd1:    return "strobe while busy";
            4'd2:    return "reset mid-run";
            default: return "exponentiation";
        endcase
    endfunction

    task automatic check_operand(input string name, input rsa_operand_t expected,
                                 input rsa_operand_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_tests();
        int           fd;
        int           fields;
        string        line;
        logic [7:0]   id_v;
        rsa_operand_t n_v;
        rsa_operand_t e_v;
        rsa_operand_t y_v;
        rsa_operand_t exp_v;
        logic [3:0]   kind_v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comment and blank lines carry no test
                if (line.len() > HEX_DIGITS && line.substr(0, 1) != "//") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h",
                                     id_v, n_v, e_v, y_v, exp_v, kind_v);
                    if (fields == 6) begin
                        tv_id.push_back(id_v);
                        tv_n.push_back(n_v);
                        tv_e.push_back(e_v);
                        tv_y.push_back(y_v);
                        tv_exp.push_back(exp_v);
                        tv_kind.push_back(kind_v);
                    end else begin
                        $display("malformed line in stimulus file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_start(input rsa_operand_t n_v, input rsa_operand_t e_v,
                               input rsa_operand_t y_v);
        @(posedge clk);
        valid <= 1'b1;
        op_n  <= n_v;
        op_e  <= e_v;
        op_y  <= y_v;
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic wait_for_ready(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < CYCLES_PER_TEST) begin
            @(negedge clk);
            seen = ready;
            cycles++;
        end
    endtask

    task automatic run_watchdog(input longint limit_ns);
        #(limit_ns);
        $display("watchdog expired after %0d ns, the DUT stopped responding", limit_ns);
        $display("** FAIL **");
        $finish;
    endtask

    ////////////////////////////////////////
    // test kinds
    ////////////////////////////////////////

    task automatic run_normal(input int i);
        bit seen;
        int pulses_before;
        pulses_before = ready_pulses;
        drive_start(tv_n[i], tv_e[i], tv_y[i]);
        wait_for_ready(seen);
        if (!seen) begin
            $display("test %0d: o_ready did not pulse within %0d cycles",
                     tv_id[i], CYCLES_PER_TEST);
            errors++;
        end else begin
            check_operand("o_text", tv_exp[i], text);
            @(negedge clk);
            check_bit("o_ready", 1'b0, ready);
            check_operand("o_text", tv_exp[i], text);
            if (ready_pulses - pulses_before != 1) begin
                $display("test %0d: expected one o_ready pulse, counted %0d",
                         tv_id[i], ready_pulses - pulses_before);
                errors++;
            end
        end
    endtask

    task automatic run_busy(input int i);
        bit seen;
        int pulses_before;
        pulses_before = ready_pulses;
        drive_start(tv_n[i], tv_e[i], tv_y[i]);
        repeat (500 + $urandom_range(0, 3000)) @(posedge clk);
        // different operands, must not disturb the run
        valid <= 1'b1;
        op_e  <= ~tv_e[i];
        op_y  <= ~tv_y[i];
        @(posedge clk);
        valid <= 1'b0;
        wait_for_ready(seen);
        if (!seen) begin
            $display("test %0d: o_ready did not pulse within %0d cycles",
                     tv_id[i], CYCLES_PER_TEST);
            errors++;
        end else begin
            check_operand("o_text", tv_exp[i], text);
            @(negedge clk);
            check_bit("o_ready", 1'b0, ready);
            repeat (HOLD_CYCLES) @(negedge clk);
            check_operand("o_text", tv_exp[i], text);
            if (ready_pulses - pulses_before != 1) begin
                $display("test %0d: busy strobe gave %0d o_ready pulses instead of one",
                         tv_id[i], ready_pulses - pulses_before);
                errors++;
            end
        end
    endtask

    task automatic run_reset(input int i);
        drive_start(tv_n[i], tv_e[i], tv_y[i]);
        repeat (1000 + $urandom_range(0, 20000)) @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("o_ready", 1'b0, ready);
        check_operand("o_text", '0, text);
        // the core must still compute after the abort
        run_normal(i);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : main
        longint limit_ns;
        int     err_before;
        rst   = 1'b1;
        valid = 1'b0;
        op_n  = '0;
        op_e  = '0;
        op_y  = '0;
        void'($urandom(SEED));
        load_tests();
        if (tv_n.size() == 0) begin
            $display("no tests were loaded from %s", STIM_FILE);
            $display("** FAIL **");
        end else begin
            limit_ns = (longint'(tv_n.size()) + 2) * CYCLES_PER_TEST * CLK_PERIOD_NS + 10000;
            fork
                run_watchdog(limit_ns);
            join_none
            repeat (RESET_CYCLES) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < tv_n.size(); i++) begin
                err_before = errors;
                repeat ($urandom_range(1, 16)) @(posedge clk);
                case (tv_kind[i])
                    4'd1:    run_busy(i);
                    4'd2:    run_reset(i);
                    default: run_normal(i);
                endcase
                if (errors == err_before) begin
                    passed++;
                    $display("test %0d (%s): passed", tv_id[i], kind_name(tv_kind[i]));
                end else begin
                    failed++;
                    $display("test %0d (%s): failed", tv_id[i], kind_name(tv_kind[i]));
                end
            end
            if (dut0.asrt0.fail_count != 0) begin
                $display("%0d assertion failures in the DUT", dut0.asrt0.fail_count);
                errors += dut0.asrt0.fail_count;
            end
            $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                     tv_n.size(), passed, failed, errors);
            if (errors == 0 && failed == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/rsa_stimulus.txt */
// columns: test id, modulus N, exponent e, message y, expected y^e mod N, kind
// kind 0 plain run, 1 second strobe while busy, 2 reset mid-run; all values in hex
01 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 9e3779b97f4a7c159e3779b97f4a7c159e3779b97f4a7c159e3779b97f4a7c15 0000000000000000000000000000000000000000000000000000000000000002 0000000000000000000000000000000000000000000000000000000000200000 0
02 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff d1b54a32d192ed03d1b54a32d192ed03d1b54a32d192ed03d1b54a32d192ed03 0000000000000000000000000000000000000000000000000000000000000020 0000000000000000000000000000000000000000000000000000000000008000 0
03 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 6a09e667f3bcc9086a09e667f3bcc9086a09e667f3bcc908bb67ae8584caa7c5 0000000000000100000000000000000000000000000000000000000000000000 0000010000000000000000000000000000000000000000000000000000000000 0
04 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0
05 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 3c6ef372fe94f82b3c6ef372fe94f82b3c6ef372fe94f82b3c6ef372fe94f82b 0000000000000000000000000000000000000000000000000000000000000001 0
06 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 3ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff6 0000000000000000000000000000000000000000000000000000000000000002 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0
07 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffd9 1f83d9abfb41bd6b1f83d9abfb41bd6b1f83d9abfb41bd6b1f83d9abfb41bd6b 1f83d9abfb41bd6b1f83d9abfb41bd6b1f83d9abfb41bd6b1f83d9abfb41bd6b 0
08 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 0000000000000000000000000000000000000000000000000000000000000000 510e527fade682d1510e527fade682d1510e527fade682d1510e527fade682d1 0000000000000000000000000000000000000000000000000000000000000001 0
09 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000001 a54ff53a5f1d36f1a54ff53a5f1d36f1a54ff53a5f1d36f1a54ff53a5f1d36f1 a54ff53a5f1d36f1a54ff53a5f1d36f1a54ff53a5f1d36f1a54ff53a5f1d36f1 0
0a 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 9b05688c2b3e6c1f9b05688c2b3e6c1f9b05688c2b3e6c1f5be0cd19137e2178 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0000000000000000000000000000000000000000000000000000000000000001 0
0b ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 428a2f98d728ae22428a2f98d728ae22428a2f98d728ae227137449123ef65cd fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe 0
0c 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 3c6ef372fe94f82b3c6ef372fe94f82b3c6ef372fe94f82b3c6ef372fe94f82b 3c6ef372fe94f82b3c6ef372fe94f82b3c6ef372fe94f82b3c6ef372fe94f82b 1
0d ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff d1b54a32d192ed03d1b54a32d192ed03d1b54a32d192ed03d1b54a32d192ed03 0000000000000000000000000000000000000000000000000000000000000020 0000000000000000000000000000000000000000000000000000000000008000 2

/* list.f */
+incdir+include
logic/rsa_types_pkg.sv
logic/rsa_ctrl_pkg.sv
logic/rsa_bit_counter.sv
logic/rsa_sequencer.sv
logic/rsa_operand_store.sv
logic/mont_mul.sv
logic/rsa_core.sv
verif/tb_clock.sv
verif/rsa_core_assertions.sv
verif/rsa_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rsa_core_tb -f list.f -o rsa_core_sim \
    || { echo "run.sh: build failed"; exit 1; }
out=$(./obj_dir/rsa_core_sim +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -qxF '** PASS **' && echo "run.sh: passed" \
    || { echo "run.sh: failed"; exit 1; }
